/* rtl/frame_marker_gen.sv */
`timescale 1ns/10ps

module frame_marker_gen (
	input  logic                clk,
	input  logic                reset,
	input  logic                sync_in,
	output tdd_pkg::frame_pos_t fpos
);

	logic at_last;
	logic realign;

	assign at_last = (fpos.pos == tdd_pkg::pos_t'(tdd_pkg::frame_last));

	// either a natural wrap or an external sync starts a new frame.
	assign realign = sync_in || at_last;

	////////////////////////////////////////////////////////////
	// frame position and marker
	////////////////////////////////////////////////////////////

	// pulse comes out with pos 0, so it is registered beside the count.
	// after reset pos sits at 0 with no pulse until the first wrap.
	always_ff @(posedge clk) begin
		if (reset) begin
			fpos.pos   <= '0;
			fpos.pulse <= 1'b0;
			fpos.early <= 1'b0;
		end else begin
			fpos.pulse <= realign;
			fpos.early <= sync_in && !at_last; // sync before the frame was done.
			if (realign) begin
				fpos.pos <= '0;
			end else begin
				fpos.pos <= fpos.pos + 1'b1;
			end
		end
	end

endmodule

/* rtl/tdd_cfg_regs.sv */
`timescale 1ns/10ps

module tdd_cfg_regs (
	input  logic              clk,
	input  logic              reset,
	input  tdd_pkg::cfg_wr_t  cfg_wr,
	output tdd_pkg::tdd_cfg_t cfg,
	output logic              restart
);

	tdd_pkg::tdd_mode_e mode_s1;
	tdd_pkg::tdd_mode_e mode_s2;
	logic               mode_changed;

	////////////////////////////////////////////////////////////
	// write capture
	////////////////////////////////////////////////////////////

	// cfg follows the write one cycle later.
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg.mode   <= tdd_pkg::mode_dl_full;
			cfg.ta_sel <= 1'b0;
		end else if (cfg_wr.valid) begin
			cfg.mode   <= cfg_wr.mode;
			cfg.ta_sel <= cfg_wr.ta_sel;
		end
	end

	////////////////////////////////////////////////////////////
	// mode change detection
	////////////////////////////////////////////////////////////

	// two stages behind cfg, so both sides of a change are visible at once.
	always_ff @(posedge clk) begin
		if (reset) begin
			mode_s1 <= tdd_pkg::mode_dl_full;
			mode_s2 <= tdd_pkg::mode_dl_full;
		end else begin
			mode_s1 <= cfg.mode;
			mode_s2 <= mode_s1;
		end
	end

	// high for one cycle per change; a rewrite of the same mode never shows here.
	assign mode_changed = (mode_s1 != mode_s2);

	// registered, lands three cycles after the write.
	always_ff @(posedge clk) begin
		if (reset) begin
			restart <= 1'b0;
		end else begin
			restart <= mode_changed;
		end
	end

endmodule

/* rtl/tdd_pkg.sv */
package tdd_pkg;

	////////////////////////////////////////////////////////////
	// frame timing, scaled down from the 10 ms frame.
	////////////////////////////////////////////////////////////

	localparam int frame_cyc   = 2400; // cycles per frame.
	localparam int dl_end      = 1783; // last downlink position in 70/30.
	localparam int t_gp        = 69;   // nominal guard before offset.
	localparam int ta_offset_a = 25;   // ta_sel clear.
	localparam int ta_offset_b = 39;   // ta_sel set.
	localparam int ul_len      = 548;

	// derived positions.
	localparam int pos_w      = $clog2(frame_cyc);
	localparam int frame_last = frame_cyc - 1;
	localparam int gp1_start  = dl_end + 1; // first guard position after downlink.

	typedef logic [pos_w-1:0] pos_t;

	////////////////////////////////////////////////////////////
	// test mode encoding.
	////////////////////////////////////////////////////////////

	typedef enum logic {
		mode_dl_full = 1'b0,
		mode_7030    = 1'b1
	} tdd_mode_e;

	////////////////////////////////////////////////////////////
	// bundles between the blocks.
	////////////////////////////////////////////////////////////

	// single-cycle configuration write.
	typedef struct packed {
		logic      valid;
		tdd_mode_e mode;
		logic      ta_sel;
	} cfg_wr_t;

	// held configuration.
	typedef struct packed {
		tdd_mode_e mode;
		logic      ta_sel;
	} tdd_cfg_t;

	typedef struct packed {
		logic pulse; // frame start.
		logic early; // pulse cut the previous frame short.
		pos_t pos;
	} frame_pos_t;

	// one state bit at a time, error never with a state bit.
	typedef struct packed {
		logic dl;
		logic gp1;
		logic ul;
		logic gp2;
		logic error;
	} tdd_status_t;

endpackage

/* rtl/tdd_state_ctrl.sv */
`timescale 1ns/10ps

module tdd_state_ctrl (
	input  logic                 clk,
	input  logic                 reset,
	input  tdd_pkg::tdd_cfg_t    cfg,
	input  logic                 restart,
	input  tdd_pkg::frame_pos_t  fpos,
	output tdd_pkg::tdd_status_t status
);

	typedef enum logic [2:0] {
		idle        = 3'd0,
		dl_full     = 3'd1,
		dl_7030     = 3'd2,
		gp_dl_to_ul = 3'd3,
		ul_7030     = 3'd4,
		gp_ul_to_dl = 3'd5,
		fault       = 3'd6
	} state_e;

	state_e        state;
	state_e        next_state;
	tdd_pkg::pos_t guard_len;
	tdd_pkg::pos_t ul_start;
	tdd_pkg::pos_t gp2_start;
	logic          early_pulse;
	logic          start_pulse;

	assign early_pulse = fpos.pulse && fpos.early;
	assign start_pulse = fpos.pulse && !fpos.early;

	////////////////////////////////////////////////////////////
	// window boundaries
	////////////////////////////////////////////////////////////

	// guard shrinks by the timing advance offset.
	always_ff @(posedge clk) begin
		if (cfg.ta_sel) begin
			guard_len <= tdd_pkg::pos_t'(tdd_pkg::t_gp - tdd_pkg::ta_offset_b);
		end else begin
			guard_len <= tdd_pkg::pos_t'(tdd_pkg::t_gp - tdd_pkg::ta_offset_a);
		end
	end

	// first position of the uplink and of the second guard.
	always_ff @(posedge clk) begin
		ul_start  <= tdd_pkg::pos_t'(tdd_pkg::gp1_start) + guard_len;
		gp2_start <= tdd_pkg::pos_t'(tdd_pkg::gp1_start + tdd_pkg::ul_len) + guard_len;
	end

	////////////////////////////////////////////////////////////
	// state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= next_state;
		end
	end

	// next_state is the state that belongs to the current fpos.
	always_comb begin
		next_state = state;
		if (restart) begin
			next_state = idle; // mode changed, wait for the next frame.
		end else begin
			case (state)
				idle: begin
					if (start_pulse) begin
						if (cfg.mode == tdd_pkg::mode_7030) begin
							next_state = dl_7030;
						end else begin
							next_state = dl_full;
						end
					end
				end
				dl_full: begin
					if (early_pulse) begin
						next_state = fault;
					end
				end
				dl_7030: begin
					if (early_pulse) begin
						next_state = fault;
					end else if (fpos.pos == tdd_pkg::pos_t'(tdd_pkg::gp1_start)) begin
						next_state = gp_dl_to_ul;
					end
				end
				gp_dl_to_ul: begin
					if (early_pulse) begin
						next_state = fault;
					end else if (start_pulse) begin
						next_state = dl_7030;
					end else if (fpos.pos == ul_start) begin
						next_state = ul_7030;
					end
				end
				ul_7030: begin
					if (early_pulse) begin
						next_state = fault;
					end else if (start_pulse) begin
						next_state = dl_7030;
					end else if (fpos.pos == gp2_start) begin
						next_state = gp_ul_to_dl;
					end
				end
				gp_ul_to_dl: begin
					if (early_pulse) begin
						next_state = fault;
					end else if (start_pulse) begin
						next_state = dl_7030; // frame wrap.
					end
				end
				fault: begin
					next_state = idle;
				end
				default: begin
					next_state = idle;
				end
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// status
	////////////////////////////////////////////////////////////

	// status lags fpos by one cycle.
	always_ff @(posedge clk) begin
		if (reset) begin
			status <= '0;
		end else begin
			status.dl  <= (next_state == dl_full) || (next_state == dl_7030);
			status.gp1 <= (next_state == gp_dl_to_ul);
			status.ul  <= (next_state == ul_7030);
			status.gp2 <= (next_state == gp_ul_to_dl);
			if (next_state == fault) begin
				status.error <= 1'b1;
			end else if (fpos.pulse) begin
				status.error <= 1'b0; // held until the following frame start.
			end
		end
	end

endmodule

/* rtl/tdd_top.sv */
`timescale 1ns/10ps

module tdd_top (
	input  logic                 clk,
	input  logic                 reset,
	input  tdd_pkg::cfg_wr_t     cfg_wr,
	input  logic                 sync_in,
	output tdd_pkg::tdd_status_t status
);

	tdd_pkg::tdd_cfg_t   cfg_q;
	logic                restart;
	tdd_pkg::frame_pos_t fpos;

	// settings and mode change strobe.
	tdd_cfg_regs u_cfg_regs (
		.clk     (clk),
		.reset   (reset),
		.cfg_wr  (cfg_wr),
		.cfg     (cfg_q),
		.restart (restart)
	);

	// frame position, one cycle behind sync_in.
	frame_marker_gen u_frame_marker (
		.clk     (clk),
		.reset   (reset),
		.sync_in (sync_in),
		.fpos    (fpos)
	);

	tdd_state_ctrl u_state_ctrl (
		.clk     (clk),
		.reset   (reset),
		.cfg     (cfg_q),
		.restart (restart),
		.fpos    (fpos),
		.status  (status)
	);

endmodule

/* src.f */
rtl/tdd_pkg.sv
rtl/tdd_cfg_regs.sv
rtl/frame_marker_gen.sv
rtl/tdd_state_ctrl.sv
rtl/tdd_top.sv
verif/tdd_props.sv
verif/tdd_tb.sv

/* verif/tdd_props.sv */
`timescale 1ns/10ps

module tdd_props (
	input logic                 clk,
	input logic                 reset,
	input tdd_pkg::tdd_status_t status
);

	////////////////////////////////////////////////////////////
	// status properties
	////////////////////////////////////////////////////////////

	// one window at a time.
	state_onehot: assert property (@(posedge clk) disable iff (reset)
		$onehot0({status.dl, status.gp1, status.ul, status.gp2}))
		else $error("more than one state bit high in status");

	// all bits low in the cycle after reset.
	reset_clears: assert property (@(posedge clk)
		reset |=> (status == '0))
		else $error("status not cleared after reset");

	error_alone: assert property (@(posedge clk) disable iff (reset)
		!(status.error && (status.dl || status.gp1 || status.ul || status.gp2)))
		else $error("error flag high together with a state bit");

endmodule

bind tdd_state_ctrl tdd_props u_props (
	.clk    (clk),
	.reset  (reset),
	.status (status)
);

/* verif/tdd_tb.sv */
`timescale 1ns/10ps

module tdd_tb;

	typedef enum {
		ph_idle, ph_dl_full, ph_dl, ph_gp1, ph_ul, ph_gp2, ph_fault
	} phase_e;

	logic                 clk;
	logic                 reset;
	tdd_pkg::cfg_wr_t     cfg_wr;
	logic                 sync_in;
	tdd_pkg::tdd_status_t status;

	// reference model state.
	int                   m_pos;
	logic                 m_pulse;
	logic                 m_early;
	tdd_pkg::tdd_cfg_t    m_cfg;
	tdd_pkg::tdd_mode_e   m_mode_d1;
	tdd_pkg::tdd_mode_e   m_mode_d2;
	logic                 m_restart;
	int                   m_guard;
	int                   m_ul_start;
	int                   m_gp2_start;
	phase_e               m_phase;
	tdd_pkg::tdd_status_t m_status;

	tdd_top DUT (
		.clk     (clk),
		.reset   (reset),
		.cfg_wr  (cfg_wr),
		.sync_in (sync_in),
		.status  (status)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	function automatic phase_e next_phase();
		logic   start;
		logic   early_p;
		phase_e nxt;
		start   = m_pulse && !m_early;
		early_p = m_pulse && m_early;
		nxt     = m_phase;
		if (m_restart) begin
			nxt = ph_idle; // mode change wins.
		end else if (m_phase == ph_idle) begin
			if (start) begin
				nxt = (m_cfg.mode == tdd_pkg::mode_7030) ? ph_dl : ph_dl_full;
			end
		end else if (m_phase == ph_fault) begin
			nxt = ph_idle;
		end else if (early_p) begin
			nxt = ph_fault;
		end else if (m_phase != ph_dl_full) begin
			// each 70/30 window is entered at its first position.
			if (start) begin
				nxt = ph_dl;
			end else if (m_phase == ph_dl && m_pos == tdd_pkg::dl_end + 1) begin
				nxt = ph_gp1;
			end else if (m_phase == ph_gp1 && m_pos == m_ul_start) begin
				nxt = ph_ul;
			end else if (m_phase == ph_ul && m_pos == m_gp2_start) begin
				nxt = ph_gp2;
			end
		end
		return nxt;
	endfunction

	task automatic advance_model();
		phase_e nxt;
		logic   wrap;
		wrap = (m_pos == tdd_pkg::frame_cyc - 1);
		nxt  = next_phase();
		// boundaries trail ta_sel by two clocks even in reset.
		m_ul_start  = tdd_pkg::dl_end + 1 + m_guard;
		m_gp2_start = tdd_pkg::dl_end + 1 + m_guard + tdd_pkg::ul_len;
		m_guard     = tdd_pkg::t_gp -
			(m_cfg.ta_sel ? tdd_pkg::ta_offset_b : tdd_pkg::ta_offset_a);
		if (reset) begin
			m_pos     = 0;
			m_pulse   = 1'b0;
			m_early   = 1'b0;
			m_cfg     = '0;
			m_mode_d1 = tdd_pkg::mode_dl_full;
			m_mode_d2 = tdd_pkg::mode_dl_full;
			m_restart = 1'b0;
			m_phase   = ph_idle;
			m_status  = '0;
		end else begin
			m_status.dl  = (nxt == ph_dl_full) || (nxt == ph_dl);
			m_status.gp1 = (nxt == ph_gp1);
			m_status.ul  = (nxt == ph_ul);
			m_status.gp2 = (nxt == ph_gp2);
			if (nxt == ph_fault) begin
				m_status.error = 1'b1;
			end else if (m_pulse) begin
				m_status.error = 1'b0;
			end
			m_phase   = nxt;
			m_restart = (m_mode_d1 != m_mode_d2);
			m_mode_d2 = m_mode_d1;
			m_mode_d1 = m_cfg.mode;
			if (cfg_wr.valid) begin
				m_cfg.mode   = cfg_wr.mode;
				m_cfg.ta_sel = cfg_wr.ta_sel;
			end
			m_pulse = sync_in || wrap;
			m_early = sync_in && !wrap; // frame cut short.
			m_pos   = (sync_in || wrap) ? 0 : m_pos + 1;
		end
	endtask

	always @(posedge clk) begin
		advance_model();
	end

	////////////////////////////////////////////////////////////
	// checks and stimulus helpers
	////////////////////////////////////////////////////////////

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_status(tdd_pkg::tdd_status_t got, tdd_pkg::tdd_status_t exp,
		string what);
		if (got !== exp) begin
			$display("mismatch at %0d ns: %s, status got %b expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_cfg(tdd_pkg::tdd_cfg_t got, tdd_pkg::tdd_cfg_t exp, string what);
		if (got !== exp) begin
			$display("mismatch at %0d ns: %s, cfg got %b expected %b", $time, what, got, exp);
			abort_run();
		end
	endtask

	// one clock and a compare on the falling edge.
	task automatic next_cycle();
		@(negedge clk);
		check_status(status, m_status, "status against model");
		check_cfg(DUT.cfg_q, m_cfg, "held configuration");
	endtask

	task automatic run_cycles(int n);
		repeat (n) next_cycle();
	endtask

	task automatic wait_frame_start();
		for (int i = 0; i < tdd_pkg::frame_cyc + 8; i++) begin
			next_cycle();
			if (DUT.fpos.pulse) begin
				return;
			end
		end
		$display("timeout: no frame pulse within %0d cycles", tdd_pkg::frame_cyc + 8);
		abort_run();
	endtask

	task automatic wait_pos(int p);
		for (int i = 0; i < tdd_pkg::frame_cyc + 8; i++) begin
			if (DUT.fpos.pos == p) begin
				return;
			end
			next_cycle();
		end
		$display("timeout: frame position %0d never reached", p);
		abort_run();
	endtask

	task automatic write_cfg(tdd_pkg::tdd_mode_e mode, logic ta_sel);
		cfg_wr.valid  = 1'b1;
		cfg_wr.mode   = mode;
		cfg_wr.ta_sel = ta_sel;
		next_cycle();
		cfg_wr.valid = 1'b0;
	endtask

	task automatic pulse_sync();
		sync_in = 1'b1;
		next_cycle();
		sync_in = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		tdd_pkg::tdd_status_t exp;
		tdd_pkg::tdd_mode_e   other;
		void'($urandom(35));
		clk         = 1'b0;
		reset       = 1'b1;
		cfg_wr      = '0;
		sync_in     = 1'b0;
		m_guard     = 0;
		m_ul_start  = 0;
		m_gp2_start = 0;
		m_status    = '0;
		repeat (2) next_cycle();
		reset = 1'b0;

		// full downlink after reset.
		wait_frame_start();
		run_cycles(3 * tdd_pkg::frame_cyc + $urandom_range(0, 500));
		exp    = '0;
		exp.dl = 1'b1;
		check_status(status, exp, "dl held in full downlink mode");

		// 70/30 with offset a and then offset b by a same-mode write.
		write_cfg(tdd_pkg::mode_7030, 1'b0);
		run_cycles(3);
		check_status(status, '0, "idle four cycles after a mode change");
		wait_frame_start();
		run_cycles($urandom_range(2, 3) * tdd_pkg::frame_cyc + $urandom_range(0, 2000));
		write_cfg(tdd_pkg::mode_7030, 1'b1);
		run_cycles($urandom_range(2, 3) * tdd_pkg::frame_cyc + $urandom_range(0, 2000));

		// early pulses in mid-frame.
		for (int k = 0; k < 4; k++) begin
			wait_frame_start();
			run_cycles($urandom_range(20, tdd_pkg::frame_cyc - 40));
			pulse_sync();
			next_cycle();
			exp       = '0;
			exp.error = 1'b1;
			check_status(status, exp, "error after an early frame pulse");
		end
		wait_frame_start();
		next_cycle();
		exp    = '0;
		exp.dl = 1'b1;
		check_status(status, exp, "pattern restarts after a fault");

		// sync on the last position is a normal frame start.
		wait_pos(tdd_pkg::frame_cyc - 1);
		pulse_sync();
		next_cycle();
		check_status(status, exp, "sync on the last position is not early");

		// random mode changes and repeated writes.
		for (int k = 0; k < 4; k++) begin
			run_cycles($urandom_range(50, 2 * tdd_pkg::frame_cyc));
			other = (m_cfg.mode == tdd_pkg::mode_7030) ?
				tdd_pkg::mode_dl_full : tdd_pkg::mode_7030;
			write_cfg(other, $urandom_range(0, 1));
			run_cycles(3);
			check_status(status, '0, "idle four cycles after a mode change");
			wait_frame_start();
			next_cycle();
			exp    = '0;
			exp.dl = 1'b1;
			check_status(status, exp, "new pattern at the next pulse");
			write_cfg(other, $urandom_range(0, 1)); // same mode again while dl runs.
			run_cycles(8);
			check_status(status, exp, "same-mode write keeps the pattern");
			run_cycles(tdd_pkg::frame_cyc);
		end

		// reset in the middle of a pattern.
		run_cycles($urandom_range(100, tdd_pkg::frame_cyc));
		reset = 1'b1;
		run_cycles(2);
		check_status(status, '0, "status cleared by reset");
		reset = 1'b0;
		wait_frame_start();
		run_cycles(2 * tdd_pkg::frame_cyc);

		$display("PASS: all tests");
		$finish;
	end

endmodule
